/* Bender.yml */
package:
  name: frogger

sources:
  - hw/frogger_pkg.sv
  - hw/scan_if.sv
  - hw/scan_counter.sv
  - hw/car_lane.sv
  - hw/frog_ctrl.sv
  - hw/pixel_render.sv
  - hw/score_display.sv
  - hw/frogger_top.sv
  - target: test
    files:
      - dv/tb_frogger.sv

/* dv/tb_frogger.sv */
module tb_frogger;

	// Small frame with 4-pixel tiles
	localparam int c_COLS      = 64;
	localparam int c_ROWS      = 60;
	localparam int c_ACT_COLS  = 48;
	localparam int c_ACT_ROWS  = 52;
	localparam int c_TILE_BITS = 2;
	localparam int c_BASE_SLOW = 2;
	localparam int c_FRAME     = c_COLS * c_ROWS;
	localparam int c_TILE      = 1 << c_TILE_BITS;
	localparam int c_HALF      = c_TILE / 2;
	// Buttons let go here after the last tile centre
	localparam int c_RELEASE_PIX = 3600;

	// Frame counts per test
	localparam int c_RAND_FRAMES   = 24;
	localparam int c_SCROLL_FRAMES = 30;
	localparam int c_HIT_LIMIT     = 200;
	localparam int c_SCORE_LIMIT   = 300;
	localparam int c_MAX_FRAMES    = 3 + (2 + 8 + c_RAND_FRAMES) + c_SCROLL_FRAMES +
	                                 (c_HIT_LIMIT + 3) + (c_SCORE_LIMIT + 1) + 20;

	// Button codes
	localparam int c_NONE  = 0;
	localparam int c_UP    = 1;
	localparam int c_DOWN  = 2;
	localparam int c_LEFT  = 3;
	localparam int c_RIGHT = 4;
	localparam int c_START = 5;

	// Model game states
	localparam int c_IDLE = 0;
	localparam int c_RUN  = 1;
	localparam int c_OVER = 2;

	// Expected {r, g, b} per tile class
	localparam logic [11:0] c_RGB_FROG  = 12'h0f0;
	localparam logic [11:0] c_RGB_CAR   = 12'hf00;
	localparam logic [11:0] c_RGB_WATER = 12'h10e;
	localparam logic [11:0] c_RGB_SAFE  = 12'h30f;
	localparam logic [11:0] c_RGB_BLACK = 12'h000;

	logic       i_Clk;
	logic       i_rst_n;
	logic       i_HSync;
	logic       i_VSync;
	logic       i_Game_Start;
	logic       i_Up_Mvt;
	logic       i_Down_Mvt;
	logic       i_Left_Mvt;
	logic       i_Right_Mvt;
	logic       o_HSync;
	logic       o_VSync;
	logic [3:0] o_Red_Video;
	logic [3:0] o_Grn_Video;
	logic [3:0] o_Blu_Video;
	logic       o_LED_1;
	logic       o_LED_2;
	logic       o_LED_3;
	logic       o_LED_4;
	logic [6:0] o_Segment1;
	logic [6:0] o_Segment2;

	// Pixel index of the current cycle as the DUT counts it
	int          pix;
	int          cycle_cnt;
	logic [31:0] lfsr;
	string       test_name;
	int          test_checks;
	int          test_errors;
	int          total_checks;
	int          total_errors;

	// Frame-level game model
	int m_state;
	int m_lives;
	int m_score;
	int m_frog_x;
	int m_frog_y;
	int m_car_col[5];
	int m_car_cnt[5];

	frogger_top #(
		.c_TOTAL_COLS (c_COLS),
		.c_TOTAL_ROWS (c_ROWS),
		.c_ACTIVE_COLS(c_ACT_COLS),
		.c_ACTIVE_ROWS(c_ACT_ROWS),
		.c_TILE_BITS  (c_TILE_BITS),
		.c_BASE_SLOW  (c_BASE_SLOW)
	) i_frogger_top (
		.i_Clk       (i_Clk),
		.i_rst_n     (i_rst_n),
		.i_HSync     (i_HSync),
		.i_VSync     (i_VSync),
		.i_Game_Start(i_Game_Start),
		.i_Up_Mvt    (i_Up_Mvt),
		.i_Down_Mvt  (i_Down_Mvt),
		.i_Left_Mvt  (i_Left_Mvt),
		.i_Right_Mvt (i_Right_Mvt),
		.o_HSync     (o_HSync),
		.o_VSync     (o_VSync),
		.o_Red_Video (o_Red_Video),
		.o_Grn_Video (o_Grn_Video),
		.o_Blu_Video (o_Blu_Video),
		.o_LED_1     (o_LED_1),
		.o_LED_2     (o_LED_2),
		.o_LED_3     (o_LED_3),
		.o_LED_4     (o_LED_4),
		.o_Segment1  (o_Segment1),
		.o_Segment2  (o_Segment2)
	);

	initial begin
		i_Clk = 1'b0;
		forever #10 i_Clk = ~i_Clk;
	end

	// HSync pulse near the line end
	function automatic logic hsync_at(input int p);
		return ((p % c_COLS) >= 52) && ((p % c_COLS) < 58);
	endfunction

	// Rises on the last pixel so the DUT count wraps in step with ours
	function automatic logic vsync_at(input int p);
		return (p == c_FRAME - 1) || (p < c_COLS);
	endfunction

	// Sync source held at pixel 0 in reset
	always @(posedge i_Clk) begin : raster
		int next_pix;
		if (!i_rst_n) begin
			next_pix = 0;
		end else begin
			next_pix = (pix == c_FRAME - 1) ? 0 : pix + 1;
		end
		pix     <= next_pix;
		i_HSync <= hsync_at(next_pix);
		i_VSync <= vsync_at(next_pix);
	end

	// Galois LFSR on x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// One LFSR step per bit
	function automatic int take_bits(input int n);
		int b;
		int val;
		val = 0;
		for (b = 0; b < n; b++) begin
			lfsr = lfsr_step(lfsr);
			val  = (val << 1) | lfsr[0];
		end
		return val;
	endfunction

	// Active-low {g..a} digit patterns
	function automatic logic [6:0] seg_pattern(input int d);
		case (d)
			0:       return 7'b1000000;
			1:       return 7'b1111001;
			2:       return 7'b0100100;
			3:       return 7'b0110000;
			4:       return 7'b0011001;
			5:       return 7'b0010010;
			6:       return 7'b0000010;
			7:       return 7'b1111000;
			8:       return 7'b0000000;
			default: return 7'b0010000;
		endcase
	endfunction

	// Model colour of the pixel yoff lines down a tile, mid column
	function automatic logic [11:0] expected_colour(input int tx, input int ty, input int yoff);
		int i;
		if ((tx << c_TILE_BITS) + c_HALF >= c_ACT_COLS ||
		    (ty << c_TILE_BITS) + yoff >= c_ACT_ROWS) begin
			return c_RGB_BLACK;
		end
		if (tx == m_frog_x && ty == m_frog_y) begin
			return c_RGB_FROG;
		end
		for (i = 0; i < 5; i++) begin
			if (ty == 11 - i && tx == m_car_col[i]) begin
				return c_RGB_CAR;
			end
		end
		// Lily row 0 and water rows 1 to 5 share a colour
		if (ty <= 5) begin
			return c_RGB_WATER;
		end
		if (ty == 6 || ty == 12) begin
			// Safe tiles keep a black border on their first and last lines
			if (yoff == 0 || yoff == c_TILE - 1) begin
				return c_RGB_BLACK;
			end
			return c_RGB_SAFE;
		end
		return c_RGB_BLACK;
	endfunction

	task automatic compare_value(input string what, input logic [31:0] exp,
	                             input logic [31:0] got);
		test_checks++;
		assert (got === exp) else begin
			test_errors++;
			$display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, got);
		end
	endtask

	task automatic confirm_goal(input logic cond, input string msg);
		test_checks++;
		assert (cond) else begin
			test_errors++;
			$display("%s: %s", test_name, msg);
		end
	endtask

	task automatic end_test();
		$display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		test_checks  = 0;
		test_errors  = 0;
	endtask

	// Stop at the falling edge of a given pixel
	task automatic wait_pix(input int p);
		do begin
			@(negedge i_Clk);
		end while (pix != p);
	endtask

	// LEDs and score digits against the model
	task automatic verify_status();
		compare_value("led_1", m_lives >= 1, o_LED_1);
		compare_value("led_2", m_lives >= 2, o_LED_2);
		compare_value("led_3", m_lives >= 3, o_LED_3);
		compare_value("led_4", m_state == c_RUN, o_LED_4);
		compare_value("segment1", seg_pattern(m_score / 10), o_Segment1);
		compare_value("segment2", seg_pattern(m_score % 10), o_Segment2);
	endtask

	// Tick rule with the hit checked before the cars step
	task automatic advance_model(input int press);
		int  i;
		int  nx;
		int  ny;
		logic hit;
		logic restart;
		hit = 1'b0;
		for (i = 0; i < 5; i++) begin
			if (m_car_col[i] == m_frog_x && 11 - i == m_frog_y) begin
				hit = 1'b1;
			end
		end
		restart = (press == c_START) && (m_state != c_RUN);
		if (m_state == c_RUN) begin
			nx = m_frog_x;
			ny = m_frog_y;
			case (press)
				c_UP:    ny = (ny > 0) ? ny - 1 : ny;
				c_DOWN:  ny = (ny < 12) ? ny + 1 : ny;
				c_LEFT:  nx = (nx > 0) ? nx - 1 : nx;
				c_RIGHT: nx = (nx < 13) ? nx + 1 : nx;
				default: ;
			endcase
			if (hit) begin
				m_lives--;
				nx = 7;
				ny = 12;
				if (m_lives == 0) begin
					m_state = c_OVER;
				end
			end else if (ny == 0) begin
				// Lily row scores and sends the frog back to start
				m_score = (m_score < 99) ? m_score + 1 : m_score;
				nx = 7;
				ny = 12;
			end
			m_frog_x = nx;
			m_frog_y = ny;
		end else if (restart) begin
			m_state  = c_RUN;
			m_lives  = 3;
			m_score  = 0;
			m_frog_x = 7;
			m_frog_y = 12;
		end
		// Lane i steps every c_BASE_SLOW + i ticks
		for (i = 0; i < 5; i++) begin
			if (restart) begin
				m_car_cnt[i] = 0;
				m_car_col[i] = 0;
			end else if (m_car_cnt[i] == c_BASE_SLOW + i - 1) begin
				m_car_cnt[i] = 0;
				m_car_col[i] = (m_car_col[i] == 13) ? 0 : m_car_col[i] + 1;
			end else begin
				m_car_cnt[i]++;
			end
		end
	endtask

	// Press, pixel checks and status for one frame before the model tick
	task automatic run_frame(input int press);
		int tx;
		int ty;
		int p;
		wait_pix(0);
		@(posedge i_Clk);
		i_Up_Mvt     <= (press == c_UP);
		i_Down_Mvt   <= (press == c_DOWN);
		i_Left_Mvt   <= (press == c_LEFT);
		i_Right_Mvt  <= (press == c_RIGHT);
		i_Game_Start <= (press == c_START);
		for (ty = 0; ty < 13; ty++) begin
			// Top line of each tile in the row
			for (tx = 0; tx < 14; tx++) begin
				p = (ty << c_TILE_BITS) * c_COLS + (tx << c_TILE_BITS) + c_HALF;
				// Colour lags the count by two cycles
				wait_pix(p + 2);
				compare_value($sformatf("rgb at tile top %0d,%0d", tx, ty),
				              expected_colour(tx, ty, 0),
				              {o_Red_Video, o_Grn_Video, o_Blu_Video});
			end
			// Tile centres
			for (tx = 0; tx < 14; tx++) begin
				p = ((ty << c_TILE_BITS) + c_HALF) * c_COLS + (tx << c_TILE_BITS) + c_HALF;
				wait_pix(p + 2);
				compare_value($sformatf("rgb at tile %0d,%0d", tx, ty),
				              expected_colour(tx, ty, c_HALF),
				              {o_Red_Video, o_Grn_Video, o_Blu_Video});
			end
		end
		wait_pix(c_RELEASE_PIX);
		verify_status();
		@(posedge i_Clk);
		i_Up_Mvt     <= 1'b0;
		i_Down_Mvt   <= 1'b0;
		i_Left_Mvt   <= 1'b0;
		i_Right_Mvt  <= 1'b0;
		i_Game_Start <= 1'b0;
		advance_model(press);
	endtask

	// Whole frame of sync outputs against inputs two cycles back
	task automatic sync_frame();
		int   k;
		logic hs_d1;
		logic hs_d2;
		logic vs_d1;
		logic vs_d2;
		wait_pix(0);
		for (k = 0; k < c_FRAME; k++) begin
			if (k > 0) begin
				@(negedge i_Clk);
			end
			if (k >= 2) begin
				compare_value("hsync delay", hs_d2, o_HSync);
				compare_value("vsync delay", vs_d2, o_VSync);
			end
			hs_d2 = hs_d1;
			hs_d1 = i_HSync;
			vs_d2 = vs_d1;
			vs_d1 = i_VSync;
		end
		advance_model(c_NONE);
	endtask

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < c_MAX_FRAMES * c_FRAME) begin
			@(posedge i_Clk);
			cycle_cnt++;
		end
		$display("Timeout: run still going after %0d cycles", cycle_cnt);
		$display("Done: errors found");
		$finish;
	end

	initial begin : main
		int k;
		int press;
		int frames;
		i_rst_n      = 1'b0;
		i_HSync      = 1'b0;
		i_VSync      = 1'b1;
		i_Game_Start = 1'b0;
		i_Up_Mvt     = 1'b0;
		i_Down_Mvt   = 1'b0;
		i_Left_Mvt   = 1'b0;
		i_Right_Mvt  = 1'b0;
		pix          = 0;
		lfsr         = 32'h141cc120;
		test_checks  = 0;
		test_errors  = 0;
		total_checks = 0;
		total_errors = 0;
		m_state      = c_IDLE;
		m_lives      = 3;
		m_score      = 0;
		m_frog_x     = 7;
		m_frog_y     = 12;
		for (k = 0; k < 5; k++) begin
			m_car_col[k] = 0;
			m_car_cnt[k] = 0;
		end

		// Outputs while reset is still held
		test_name = "reset_idle";
		repeat (4) @(posedge i_Clk);
		@(negedge i_Clk);
		compare_value("rgb in reset", 0, {o_Red_Video, o_Grn_Video, o_Blu_Video});
		verify_status();
		@(posedge i_Clk);
		i_rst_n <= 1'b1;
		run_frame(c_NONE);
		run_frame(c_NONE);
		end_test();

		test_name = "sync_delay";
		sync_frame();
		end_test();

		// Start and clamp at the bottom and left borders before a random walk
		test_name = "frog_motion";
		run_frame(c_START);
		run_frame(c_DOWN);
		repeat (8) run_frame(c_LEFT);
		repeat (c_RAND_FRAMES) begin
			press = (take_bits(2) == 0) ? c_NONE : take_bits(2) + 1;
			run_frame(press);
		end
		end_test();

		// Lane 0 wraps within 28 frames
		test_name = "car_scroll";
		repeat (c_SCROLL_FRAMES) run_frame(c_NONE);
		end_test();

		// Park the frog on row 11 until lane 0 has run it over three times
		test_name = "collision";
		if (m_state != c_RUN) begin
			run_frame(c_START);
		end
		frames = 0;
		while (m_state != c_OVER && frames < c_HIT_LIMIT) begin
			if (m_frog_y == 12) begin
				press = c_UP;
			end else if (m_frog_y < 11) begin
				press = c_DOWN;
			end else begin
				press = c_NONE;
			end
			run_frame(press);
			frames++;
		end
		confirm_goal(m_state == c_OVER, "frog was not run over three times in the frame limit");
		run_frame(c_NONE);
		run_frame(c_START);
		run_frame(c_NONE);
		end_test();

		// Hop up until two points are on the display
		test_name = "scoring";
		frames = 0;
		while (m_score < 2 && frames < c_SCORE_LIMIT) begin
			press = (m_state == c_RUN) ? c_UP : c_START;
			run_frame(press);
			frames++;
		end
		confirm_goal(m_score >= 2, "frog did not reach the lily row twice in the frame limit");
		run_frame(c_NONE);
		end_test();

		$display("all tests: %0d checks, %0d errors", total_checks, total_errors);
		if (total_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* flist.f */
hw/frogger_pkg.sv
hw/scan_if.sv
hw/scan_counter.sv
hw/car_lane.sv
hw/frog_ctrl.sv
hw/pixel_render.sv
hw/score_display.sv
hw/frogger_top.sv
dv/tb_frogger.sv

/* hw/car_lane.sv */
module car_lane #(
	parameter int c_LANE_ROW    = 11,
	parameter int c_SLOW_FRAMES = 2
) (
	input  logic               i_Clk,
	input  logic               i_rst_n,
	input  logic               i_Restart,
	scan_if.sink               i_Scan,
	input  frogger_pkg::tile_t i_Frog_X,
	input  frogger_pkg::tile_t i_Frog_Y,
	output logic               o_Hit,
	output logic               o_Car_Here
);

	localparam int c_CNT_BITS = $clog2(c_SLOW_FRAMES + 1);
	localparam frogger_pkg::tile_t c_ROW = frogger_pkg::tile_t'(c_LANE_ROW);

	logic [c_CNT_BITS-1:0] r_frame_cnt;
	frogger_pkg::tile_t    r_car_col;
	logic                  w_step;

	// Step once every c_SLOW_FRAMES ticks
	assign w_step = i_Scan.frame_tick && (r_frame_cnt == c_CNT_BITS'(c_SLOW_FRAMES - 1));

	always_ff @(posedge i_Clk) begin
		if (!i_rst_n) begin
			r_frame_cnt <= '0;
			r_car_col   <= '0;
		end else if (i_Restart) begin
			// New game, car back to the left edge
			r_frame_cnt <= '0;
			r_car_col   <= '0;
		end else if (w_step) begin
			r_frame_cnt <= '0;
			// Wrap 13 -> 0
			if (r_car_col == frogger_pkg::tile_t'(frogger_pkg::c_GAME_WIDTH - 1)) begin
				r_car_col <= '0;
			end else begin
				r_car_col <= r_car_col + 1'b1;
			end
		end else if (i_Scan.frame_tick) begin
			r_frame_cnt <= r_frame_cnt + 1'b1;
		end
	end

	// Car tile equals frog tile
	assign o_Hit      = (r_car_col == i_Frog_X) && (c_ROW == i_Frog_Y);
	// Pixel lies on the car tile
	assign o_Car_Here = i_Scan.in_field && (i_Scan.row_tile == c_ROW) &&
	                    (i_Scan.col_tile == r_car_col);

	a_car_col_range: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
		r_car_col < frogger_pkg::c_GAME_WIDTH);

endmodule

/* hw/frog_ctrl.sv */
module frog_ctrl (
	input  logic                i_Clk,
	input  logic                i_rst_n,
	input  logic                i_Game_Start,
	input  logic                i_Up_Mvt,
	input  logic                i_Down_Mvt,
	input  logic                i_Left_Mvt,
	input  logic                i_Right_Mvt,
	input  logic                i_Frame_Tick,
	input  logic                i_Hit,
	output frogger_pkg::tile_t  o_Frog_X,
	output frogger_pkg::tile_t  o_Frog_Y,
	output frogger_pkg::score_t o_Score,
	output frogger_pkg::lives_t o_Lives,
	output logic                o_Running,
	output logic                o_Restart
);

	frogger_pkg::game_state_e r_state;
	frogger_pkg::tile_t       r_frog_x;
	frogger_pkg::tile_t       r_frog_y;
	frogger_pkg::score_t      r_score;
	frogger_pkg::lives_t      r_lives;
	// Buttons as {start, up, down, left, right}
	logic [4:0]               w_btn;
	logic [4:0]               r_btn_d;
	logic [4:0]               w_rise;
	// Pending moves as {up, down, left, right}
	logic [3:0]               r_move_pend;
	logic                     r_start_pend;
	frogger_pkg::tile_t       w_move_x;
	frogger_pkg::tile_t       w_move_y;

	assign w_btn  = {i_Game_Start, i_Up_Mvt, i_Down_Mvt, i_Left_Mvt, i_Right_Mvt};
	assign w_rise = w_btn & ~r_btn_d;

	// Edge capture, held until the next tick
	always_ff @(posedge i_Clk) begin
		if (!i_rst_n) begin
			r_btn_d      <= '0;
			r_move_pend  <= '0;
			r_start_pend <= 1'b0;
		end else begin
			r_btn_d <= w_btn;
			if (i_Frame_Tick) begin
				r_move_pend  <= '0;
				r_start_pend <= 1'b0;
			end else begin
				r_move_pend  <= r_move_pend | w_rise[3:0];
				r_start_pend <= r_start_pend | w_rise[4];
			end
		end
	end

	// One move per frame, up > down > left > right, clamped at the grid border
	always_comb begin
		w_move_x = r_frog_x;
		w_move_y = r_frog_y;
		if (r_move_pend[3]) begin
			if (r_frog_y != '0) begin
				w_move_y = r_frog_y - 1'b1;
			end
		end else if (r_move_pend[2]) begin
			if (r_frog_y < frogger_pkg::c_GAME_HEIGHT - 1) begin
				w_move_y = r_frog_y + 1'b1;
			end
		end else if (r_move_pend[1]) begin
			if (r_frog_x != '0) begin
				w_move_x = r_frog_x - 1'b1;
			end
		end else if (r_move_pend[0]) begin
			if (r_frog_x < frogger_pkg::c_GAME_WIDTH - 1) begin
				w_move_x = r_frog_x + 1'b1;
			end
		end
	end

	// Game state only moves on the frame tick
	always_ff @(posedge i_Clk) begin
		if (!i_rst_n) begin
			r_state  <= frogger_pkg::IDLE;
			r_lives  <= frogger_pkg::c_START_LIVES;
			r_score  <= '0;
			r_frog_x <= frogger_pkg::c_START_X;
			r_frog_y <= frogger_pkg::c_START_Y;
		end else if (i_Frame_Tick) begin
			case (r_state)
				frogger_pkg::RUNNING: begin
					if (i_Hit) begin
						// Hit wins over any pending move
						r_lives  <= r_lives - 1'b1;
						r_frog_x <= frogger_pkg::c_START_X;
						r_frog_y <= frogger_pkg::c_START_Y;
						if (r_lives == 2'd1) begin
							r_state <= frogger_pkg::OVER;
						end
					end else if (w_move_y == '0) begin
						// Lily row reached
						if (r_score != frogger_pkg::c_MAX_SCORE) begin
							r_score <= r_score + 1'b1;
						end
						r_frog_x <= frogger_pkg::c_START_X;
						r_frog_y <= frogger_pkg::c_START_Y;
					end else begin
						r_frog_x <= w_move_x;
						r_frog_y <= w_move_y;
					end
				end
				default: begin
					// IDLE or OVER, wait for start
					if (r_start_pend) begin
						r_state  <= frogger_pkg::RUNNING;
						r_lives  <= frogger_pkg::c_START_LIVES;
						r_score  <= '0;
						r_frog_x <= frogger_pkg::c_START_X;
						r_frog_y <= frogger_pkg::c_START_Y;
					end
				end
			endcase
		end
	end

	assign o_Frog_X  = r_frog_x;
	assign o_Frog_Y  = r_frog_y;
	assign o_Score   = r_score;
	assign o_Lives   = r_lives;
	assign o_Running = (r_state == frogger_pkg::RUNNING);
	// Cars restart on the same tick the game does
	assign o_Restart = i_Frame_Tick && r_start_pend && (r_state != frogger_pkg::RUNNING);

	a_lives_no_gain: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
		!o_Restart |=> (r_lives <= $past(r_lives)));

endmodule

/* hw/frogger_pkg.sv */
package frogger_pkg;

	// Playfield size in tiles
	localparam int c_GAME_WIDTH  = 14;
	localparam int c_GAME_HEIGHT = 13;
	// Road lanes, one car each
	localparam int c_NUM_LANES   = 5;

	// Tile coordinate, same width for column and row
	typedef logic [5:0] tile_t;
	// Score holds 0..99
	typedef logic [6:0] score_t;
	typedef logic [1:0] lives_t;
	// One colour channel
	typedef logic [3:0] rgb_t;

	// Start tile, middle of the bottom safe row
	localparam tile_t  c_START_X     = 6'd7;
	localparam tile_t  c_START_Y     = 6'd12;
	localparam score_t c_MAX_SCORE   = 7'd99;
	localparam lives_t c_START_LIVES = 2'd3;

	typedef enum logic [1:0] {IDLE, RUNNING, OVER} game_state_e;
	typedef enum logic [1:0] {LILY, WATER, SAFE, ROAD} terrain_e;

	// Flat tile colours
	localparam rgb_t c_FROG_RED  = 4'd0;
	localparam rgb_t c_FROG_GRN  = 4'd15;
	localparam rgb_t c_FROG_BLU  = 4'd0;
	localparam rgb_t c_CAR_RED   = 4'd15;
	localparam rgb_t c_CAR_GRN   = 4'd0;
	localparam rgb_t c_CAR_BLU   = 4'd0;
	// Lily row shares the water colour
	localparam rgb_t c_WATER_RED = 4'd1;
	localparam rgb_t c_WATER_GRN = 4'd0;
	localparam rgb_t c_WATER_BLU = 4'd14;
	localparam rgb_t c_SAFE_RED  = 4'd3;
	localparam rgb_t c_SAFE_GRN  = 4'd0;
	localparam rgb_t c_SAFE_BLU  = 4'd15;
	// Road, tile borders and off-field
	localparam rgb_t c_BLACK_RED = 4'd0;
	localparam rgb_t c_BLACK_GRN = 4'd0;
	localparam rgb_t c_BLACK_BLU = 4'd0;

	// Terrain class of a tile row
	function automatic terrain_e terrain_of_row(input tile_t row);
		terrain_e t;
		if (row == 6'd0) begin
			t = LILY;
		end else if (row <= 6'd5) begin
			t = WATER;
		end else if (row >= 6'd7 && row <= 6'd11) begin
			t = ROAD;
		end else begin
			// Rows 6 and 12
			t = SAFE;
		end
		return t;
	endfunction

endpackage

/* hw/frogger_top.sv */
module frogger_top #(
	parameter int c_TOTAL_COLS  = 800,
	parameter int c_TOTAL_ROWS  = 525,
	parameter int c_ACTIVE_COLS = 640,
	parameter int c_ACTIVE_ROWS = 480,
	parameter int c_TILE_BITS   = 5,
	parameter int c_BASE_SLOW   = 20
) (
	input  logic              i_Clk,
	input  logic              i_rst_n,
	input  logic              i_HSync,
	input  logic              i_VSync,
	input  logic              i_Game_Start,
	input  logic              i_Up_Mvt,
	input  logic              i_Down_Mvt,
	input  logic              i_Left_Mvt,
	input  logic              i_Right_Mvt,
	output logic              o_HSync,
	output logic              o_VSync,
	output frogger_pkg::rgb_t o_Red_Video,
	output frogger_pkg::rgb_t o_Grn_Video,
	output frogger_pkg::rgb_t o_Blu_Video,
	output logic              o_LED_1,
	output logic              o_LED_2,
	output logic              o_LED_3,
	output logic              o_LED_4,
	output logic [6:0]        o_Segment1,
	output logic [6:0]        o_Segment2
);

	scan_if scan_bus ();

	logic [9:0]                     w_col_count;
	logic [9:0]                     w_row_count;
	logic                           w_active;
	frogger_pkg::tile_t             w_frog_x;
	frogger_pkg::tile_t             w_frog_y;
	logic [frogger_pkg::c_NUM_LANES-1:0] w_hit;
	logic [frogger_pkg::c_NUM_LANES-1:0] w_car_here;
	logic                           w_any_hit;
	logic                           w_any_car;
	logic                           w_restart;
	logic                           w_running;
	frogger_pkg::score_t            w_score;
	frogger_pkg::lives_t            w_lives;

	scan_counter #(
		.c_TOTAL_COLS(c_TOTAL_COLS),
		.c_TOTAL_ROWS(c_TOTAL_ROWS),
		.c_TILE_BITS (c_TILE_BITS)
	) scan_counter_inst (
		.i_Clk      (i_Clk),
		.i_rst_n    (i_rst_n),
		.i_HSync    (i_HSync),
		.i_VSync    (i_VSync),
		.o_Col_Count(w_col_count),
		.o_Row_Count(w_row_count),
		.o_Scan     (scan_bus.source)
	);

	// Visible part of the frame
	assign w_active = (w_col_count < c_ACTIVE_COLS) && (w_row_count < c_ACTIVE_ROWS);

	// Lane i on row 11 - i, each lane one frame slower than the one below
	for (genvar i = 0; i < frogger_pkg::c_NUM_LANES; i++) begin : g_lane
		car_lane #(
			.c_LANE_ROW   (11 - i),
			.c_SLOW_FRAMES(c_BASE_SLOW + i)
		) car_lane_inst (
			.i_Clk     (i_Clk),
			.i_rst_n   (i_rst_n),
			.i_Restart (w_restart),
			.i_Scan    (scan_bus.sink),
			.i_Frog_X  (w_frog_x),
			.i_Frog_Y  (w_frog_y),
			.o_Hit     (w_hit[i]),
			.o_Car_Here(w_car_here[i])
		);
	end

	assign w_any_hit = |w_hit;
	assign w_any_car = |w_car_here;

	frog_ctrl frog_ctrl_inst (
		.i_Clk       (i_Clk),
		.i_rst_n     (i_rst_n),
		.i_Game_Start(i_Game_Start),
		.i_Up_Mvt    (i_Up_Mvt),
		.i_Down_Mvt  (i_Down_Mvt),
		.i_Left_Mvt  (i_Left_Mvt),
		.i_Right_Mvt (i_Right_Mvt),
		.i_Frame_Tick(scan_bus.frame_tick),
		.i_Hit       (w_any_hit),
		.o_Frog_X    (w_frog_x),
		.o_Frog_Y    (w_frog_y),
		.o_Score     (w_score),
		.o_Lives     (w_lives),
		.o_Running   (w_running),
		.o_Restart   (w_restart)
	);

	pixel_render pixel_render_inst (
		.i_Clk      (i_Clk),
		.i_rst_n    (i_rst_n),
		.i_Scan     (scan_bus.sink),
		.i_HSync    (i_HSync),
		.i_VSync    (i_VSync),
		.i_Active   (w_active),
		.i_Frog_X   (w_frog_x),
		.i_Frog_Y   (w_frog_y),
		.i_Any_Car  (w_any_car),
		.o_HSync    (o_HSync),
		.o_VSync    (o_VSync),
		.o_Red_Video(o_Red_Video),
		.o_Grn_Video(o_Grn_Video),
		.o_Blu_Video(o_Blu_Video)
	);

	score_display score_display_inst (
		.i_Clk     (i_Clk),
		.i_rst_n   (i_rst_n),
		.i_Score   (w_score),
		.o_Segment1(o_Segment1),
		.o_Segment2(o_Segment2)
	);

	// Lives as a thermometer
	assign o_LED_1 = (w_lives >= 2'd1);
	assign o_LED_2 = (w_lives >= 2'd2);
	assign o_LED_3 = (w_lives >= 2'd3);
	assign o_LED_4 = w_running;

endmodule

/* hw/pixel_render.sv */
module pixel_render (
	input  logic               i_Clk,
	input  logic               i_rst_n,
	scan_if.sink               i_Scan,
	input  logic               i_HSync,
	input  logic               i_VSync,
	input  logic               i_Active,
	input  frogger_pkg::tile_t i_Frog_X,
	input  frogger_pkg::tile_t i_Frog_Y,
	input  logic               i_Any_Car,
	output logic               o_HSync,
	output logic               o_VSync,
	output frogger_pkg::rgb_t  o_Red_Video,
	output frogger_pkg::rgb_t  o_Grn_Video,
	output frogger_pkg::rgb_t  o_Blu_Video
);

	logic              w_frog_here;
	frogger_pkg::rgb_t w_red;
	frogger_pkg::rgb_t w_grn;
	frogger_pkg::rgb_t w_blu;
	frogger_pkg::rgb_t r_red_1;
	frogger_pkg::rgb_t r_grn_1;
	frogger_pkg::rgb_t r_blu_1;
	logic [1:0]        r_hsync_pipe;
	logic [1:0]        r_vsync_pipe;

	assign w_frog_here = (i_Scan.col_tile == i_Frog_X) && (i_Scan.row_tile == i_Frog_Y);

	// Frog over car over terrain, black off the grid
	always_comb begin
		w_red = frogger_pkg::c_BLACK_RED;
		w_grn = frogger_pkg::c_BLACK_GRN;
		w_blu = frogger_pkg::c_BLACK_BLU;
		if (i_Active && i_Scan.in_field) begin
			if (w_frog_here) begin
				w_red = frogger_pkg::c_FROG_RED;
				w_grn = frogger_pkg::c_FROG_GRN;
				w_blu = frogger_pkg::c_FROG_BLU;
			end else if (i_Any_Car) begin
				w_red = frogger_pkg::c_CAR_RED;
				w_grn = frogger_pkg::c_CAR_GRN;
				w_blu = frogger_pkg::c_CAR_BLU;
			end else begin
				case (frogger_pkg::terrain_of_row(i_Scan.row_tile))
					frogger_pkg::LILY, frogger_pkg::WATER: begin
						w_red = frogger_pkg::c_WATER_RED;
						w_grn = frogger_pkg::c_WATER_GRN;
						w_blu = frogger_pkg::c_WATER_BLU;
					end
					frogger_pkg::SAFE: begin
						// Border lines stay black
						if (!i_Scan.edge_line) begin
							w_red = frogger_pkg::c_SAFE_RED;
							w_grn = frogger_pkg::c_SAFE_GRN;
							w_blu = frogger_pkg::c_SAFE_BLU;
						end
					end
					default: begin
						// Road
						w_red = frogger_pkg::c_BLACK_RED;
						w_grn = frogger_pkg::c_BLACK_GRN;
						w_blu = frogger_pkg::c_BLACK_BLU;
					end
				endcase
			end
		end
	end

	// Two colour stages
	always_ff @(posedge i_Clk) begin
		if (!i_rst_n) begin
			r_red_1     <= '0;
			r_grn_1     <= '0;
			r_blu_1     <= '0;
			o_Red_Video <= '0;
			o_Grn_Video <= '0;
			o_Blu_Video <= '0;
		end else begin
			r_red_1     <= w_red;
			r_grn_1     <= w_grn;
			r_blu_1     <= w_blu;
			o_Red_Video <= r_red_1;
			o_Grn_Video <= r_grn_1;
			o_Blu_Video <= r_blu_1;
		end
	end

	// Sync follows the same two-cycle delay
	always_ff @(posedge i_Clk) begin
		r_hsync_pipe <= {r_hsync_pipe[0], i_HSync};
		r_vsync_pipe <= {r_vsync_pipe[0], i_VSync};
	end

	assign o_HSync = r_hsync_pipe[1];
	assign o_VSync = r_vsync_pipe[1];

endmodule

/* hw/scan_counter.sv */
module scan_counter #(
	parameter int c_TOTAL_COLS = 800,
	parameter int c_TOTAL_ROWS = 525,
	parameter int c_TILE_BITS  = 5
) (
	input  logic       i_Clk,
	input  logic       i_rst_n,
	input  logic       i_HSync,
	input  logic       i_VSync,
	output logic [9:0] o_Col_Count,
	output logic [9:0] o_Row_Count,
	scan_if.source     o_Scan
);

	logic                   r_vsync_d;
	logic                   w_frame_start;
	logic [9:0]             w_col_tile_full;
	logic [9:0]             w_row_tile_full;
	logic [c_TILE_BITS-1:0] w_row_in_tile;

	// Rising VSync marks the frame start
	assign w_frame_start = i_VSync && !r_vsync_d;

	always_ff @(posedge i_Clk) begin
		if (!i_rst_n) begin
			// Idle-high sync gives no false edge out of reset
			r_vsync_d   <= 1'b1;
			o_Col_Count <= '0;
			o_Row_Count <= '0;
		end else begin
			r_vsync_d <= i_VSync;
			if (w_frame_start) begin
				// Realign both counters to the frame
				o_Col_Count <= '0;
				o_Row_Count <= '0;
			end else if (o_Col_Count == 10'(c_TOTAL_COLS - 1)) begin
				o_Col_Count <= '0;
				// Next line, wrap at frame end
				if (o_Row_Count == 10'(c_TOTAL_ROWS - 1)) begin
					o_Row_Count <= '0;
				end else begin
					o_Row_Count <= o_Row_Count + 1'b1;
				end
			end else begin
				o_Col_Count <= o_Col_Count + 1'b1;
			end
		end
	end

	// Tile index is the count without its in-tile bits
	assign w_col_tile_full = o_Col_Count >> c_TILE_BITS;
	assign w_row_tile_full = o_Row_Count >> c_TILE_BITS;
	assign w_row_in_tile   = o_Row_Count[c_TILE_BITS-1:0];

	assign o_Scan.col_tile   = w_col_tile_full[5:0];
	assign o_Scan.row_tile   = w_row_tile_full[5:0];
	// Range check on the full index so wide counts never alias into the grid
	assign o_Scan.in_field   = (w_col_tile_full < frogger_pkg::c_GAME_WIDTH) &&
	                           (w_row_tile_full < frogger_pkg::c_GAME_HEIGHT);
	assign o_Scan.edge_line  = (w_row_in_tile == '0) || (w_row_in_tile == '1);
	assign o_Scan.frame_tick = (o_Col_Count == 10'(c_TOTAL_COLS - 1)) &&
	                           (o_Row_Count == 10'(c_TOTAL_ROWS - 1));

	// Counters wrap before the frame totals
	a_count_range: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
		(o_Col_Count < c_TOTAL_COLS) && (o_Row_Count < c_TOTAL_ROWS));

	// Line period of the incoming HSync matches the column total
	a_line_period: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
		$rose(i_HSync) |-> ##c_TOTAL_COLS $rose(i_HSync));

endmodule

/* hw/scan_if.sv */
interface scan_if;

	// Tile under the current pixel
	frogger_pkg::tile_t col_tile;
	frogger_pkg::tile_t row_tile;
	// Pixel inside the 14 x 13 grid
	logic in_field;
	// First or last line within a tile row
	logic edge_line;
	// Last pixel of the frame, one cycle wide
	logic frame_tick;

	modport source (output col_tile, row_tile, in_field, edge_line, frame_tick);
	modport sink (input col_tile, row_tile, in_field, edge_line, frame_tick);

endinterface

/* hw/score_display.sv */
module score_display (
	input  logic                i_Clk,
	input  logic                i_rst_n,
	input  frogger_pkg::score_t i_Score,
	output logic [6:0]          o_Segment1,
	output logic [6:0]          o_Segment2
);

	// Digit pattern for 0, active low
	localparam logic [6:0] c_SEG_ZERO = 7'b1000000;

	logic [3:0] w_tens;
	logic [3:0] w_ones;

	// Segments as {g, f, e, d, c, b, a}, low lights
	function automatic logic [6:0] seg_of(input logic [3:0] digit);
		logic [6:0] seg;
		case (digit)
			4'd0:    seg = c_SEG_ZERO;
			4'd1:    seg = 7'b1111001;
			4'd2:    seg = 7'b0100100;
			4'd3:    seg = 7'b0110000;
			4'd4:    seg = 7'b0011001;
			4'd5:    seg = 7'b0010010;
			4'd6:    seg = 7'b0000010;
			4'd7:    seg = 7'b1111000;
			4'd8:    seg = 7'b0000000;
			4'd9:    seg = 7'b0010000;
			default: seg = 7'b1111111;
		endcase
		return seg;
	endfunction

	// Score saturates at 99 so tens fits one digit
	assign w_tens = 4'(i_Score / 7'd10);
	assign w_ones = 4'(i_Score % 7'd10);

	always_ff @(posedge i_Clk) begin
		if (!i_rst_n) begin
			o_Segment1 <= c_SEG_ZERO;
			o_Segment2 <= c_SEG_ZERO;
		end else begin
			// Left digit tens, right digit ones
			o_Segment1 <= seg_of(w_tens);
			o_Segment2 <= seg_of(w_ones);
		end
	end

endmodule
